// ==== all.f ====
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/control_unit.sv
design/datapath.sv
design/request_unit.sv
design/cpu_top.sv
verification/cpu_chk.sv
verification/cpu_tb.sv

// ==== design/alu.sv ====
// #########################################################################
// Combinational ALU
// Add, subtract, logic ops, signed and unsigned compare, shifts, LUI,
// plus a zero flag for branch decisions
// #########################################################################

`timescale 1ns/1ps

module alu (
  input  cpu_pkg::aluop_t alu_op,
  input  cpu_pkg::word_t  port_a,
  input  cpu_pkg::word_t  port_b,
  input  logic [4:0]      shamt,
  output cpu_pkg::word_t  result,
  output logic            zero
);

  always_comb begin
    case (alu_op)
      cpu_pkg::ALU_ADD:  result = port_a + port_b;
      cpu_pkg::ALU_SUB:  result = port_a - port_b;
      cpu_pkg::ALU_AND:  result = port_a & port_b;
      cpu_pkg::ALU_OR:   result = port_a | port_b;
      cpu_pkg::ALU_XOR:  result = port_a ^ port_b;
      cpu_pkg::ALU_NOR:  result = ~(port_a | port_b);
      // Compares give 0 or 1 in bit 0
      cpu_pkg::ALU_SLT:  result = {31'b0, $signed(port_a) < $signed(port_b)};
      cpu_pkg::ALU_SLTU: result = {31'b0, port_a < port_b};
      // Shifts act on rt, amount from the shamt field
      cpu_pkg::ALU_SLL:  result = port_b << shamt;
      cpu_pkg::ALU_SRL:  result = port_b >> shamt;
      // Immediate into upper half
      cpu_pkg::ALU_LUI:  result = port_b << 16;
      default:           result = '0;
    endcase
  end

  // Equal operands on SUB give zero, used by BEQ/BNE
  assign zero = (result == '0);

endmodule

// ==== design/control_unit.sv ====
// #########################################################################
// Control unit
// Decodes opcode and R-type funct into the control struct,
// unknown encodings fall through as a no-op
// #########################################################################

`timescale 1ns/1ps

module control_unit (
  input  cpu_pkg::instr_u instr,
  output cpu_pkg::ctrl_t  ctrl
);

  always_comb begin
    // No write, no memory, no jump unless decoded below
    ctrl        = '0;
    ctrl.alu_op = cpu_pkg::ALU_ADD;
    ctrl.wb_sel = cpu_pkg::WB_ALU;

    case (instr.r.opcode)
      cpu_pkg::OP_RTYPE: begin
        ctrl.reg_dst_rd = 1'b1;
        ctrl.reg_write  = 1'b1;
        case (instr.r.funct)
          cpu_pkg::FN_ADDU: ctrl.alu_op = cpu_pkg::ALU_ADD;
          cpu_pkg::FN_SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
          cpu_pkg::FN_AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::FN_OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
          cpu_pkg::FN_XOR:  ctrl.alu_op = cpu_pkg::ALU_XOR;
          cpu_pkg::FN_NOR:  ctrl.alu_op = cpu_pkg::ALU_NOR;
          cpu_pkg::FN_SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
          cpu_pkg::FN_SLTU: ctrl.alu_op = cpu_pkg::ALU_SLTU;
          cpu_pkg::FN_SLL:  ctrl.alu_op = cpu_pkg::ALU_SLL;
          cpu_pkg::FN_SRL:  ctrl.alu_op = cpu_pkg::ALU_SRL;
          cpu_pkg::FN_JR: begin
            // Jump to rs, nothing written
            ctrl.reg_write = 1'b0;
            ctrl.jump      = cpu_pkg::JMP_REG;
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end

      // Immediate arithmetic, sign extended
      cpu_pkg::OP_ADDIU, cpu_pkg::OP_SLTI: begin
        ctrl.alu_op      = (instr.i.opcode == cpu_pkg::OP_SLTI) ?
                           cpu_pkg::ALU_SLT : cpu_pkg::ALU_ADD;
        ctrl.alu_src_imm = 1'b1;
        ctrl.ext_sign    = 1'b1;
        ctrl.reg_write   = 1'b1;
      end

      // Immediate logic, zero extended
      cpu_pkg::OP_ANDI, cpu_pkg::OP_ORI, cpu_pkg::OP_XORI: begin
        case (instr.i.opcode)
          cpu_pkg::OP_ANDI: ctrl.alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::OP_ORI:  ctrl.alu_op = cpu_pkg::ALU_OR;
          default:          ctrl.alu_op = cpu_pkg::ALU_XOR;
        endcase
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end

      cpu_pkg::OP_LUI: begin
        ctrl.alu_op      = cpu_pkg::ALU_LUI;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1;
      end

      // Address is rs + signed offset
      cpu_pkg::OP_LW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.ext_sign    = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.wb_sel      = cpu_pkg::WB_MEM;
      end
      cpu_pkg::OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.ext_sign    = 1'b1;
        ctrl.mem_write   = 1'b1;
      end

      // Compare via SUB, offset sign extended for the target
      cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
        ctrl.alu_op    = cpu_pkg::ALU_SUB;
        ctrl.ext_sign  = 1'b1;
        ctrl.branch_eq = (instr.i.opcode == cpu_pkg::OP_BEQ);
        ctrl.branch_ne = (instr.i.opcode == cpu_pkg::OP_BNE);
      end

      cpu_pkg::OP_J:   ctrl.jump = cpu_pkg::JMP_TARGET;
      cpu_pkg::OP_JAL: begin
        // Link address into $31
        ctrl.jump      = cpu_pkg::JMP_TARGET;
        ctrl.link      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = cpu_pkg::WB_PC4;
      end

      cpu_pkg::OP_HALT: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== design/cpu_pkg.sv ====
// #########################################################################
// Shared types for the MIPS-subset core
// Opcode, funct and ALU operation enums, instruction format union,
// control struct, write-back and jump selectors, and the bus structs
// #########################################################################

package cpu_pkg;

  typedef logic [31:0] word_t;

  // Major opcodes
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_JAL   = 6'b000011,
    OP_BEQ   = 6'b000100,
    OP_BNE   = 6'b000101,
    OP_ADDIU = 6'b001001,
    OP_SLTI  = 6'b001010,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_XORI  = 6'b001110,
    OP_LUI   = 6'b001111,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011,
    OP_HALT  = 6'b111111
  } opcode_t;

  // R-type function field
  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_JR   = 6'b001000,
    FN_ADDU = 6'b100001,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010,
    FN_SLTU = 6'b101011
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
  } aluop_t;

  // Three views of the same instruction word
  typedef struct packed {
    opcode_t    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_t     funct;
  } r_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } i_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr26;
  } j_t;

  typedef union packed {
    r_t r;
    i_t i;
    j_t j;
  } instr_u;

  // Write-back source select
  localparam logic [1:0] WB_MEM = 2'd0;
  localparam logic [1:0] WB_ALU = 2'd1;
  localparam logic [1:0] WB_PC4 = 2'd2;

  // Next-PC source select
  localparam logic [1:0] JMP_NONE   = 2'd0;
  localparam logic [1:0] JMP_TARGET = 2'd1;
  localparam logic [1:0] JMP_REG    = 2'd2;

  typedef struct packed {
    aluop_t     alu_op;
    logic       alu_src_imm;
    logic       ext_sign;
    logic       reg_dst_rd;
    logic       reg_write;
    logic [1:0] wb_sel;
    logic       mem_read;
    logic       mem_write;
    logic       branch_eq;
    logic       branch_ne;
    logic [1:0] jump;
    logic       link;
    logic       halt;
  } ctrl_t;

  // Data access from datapath to request unit
  typedef struct packed {
    logic  read;
    logic  write;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  // Wishbone master outputs
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
  } wb_m_t;

  // Wishbone slave outputs
  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_s_t;

endpackage

// ==== design/cpu_top.sv ====
// #########################################################################
// Core top level
// Datapath and request unit joined, Wishbone master port and halt out
// #########################################################################

`timescale 1ns/1ps

module cpu_top #(
  parameter cpu_pkg::word_t PC_INIT = '0
) (
  input  logic           CLK,
  input  logic           nRST,
  output cpu_pkg::wb_m_t wb_o,
  input  cpu_pkg::wb_s_t wb_i,
  output logic           halt
);

  // Request unit to datapath
  cpu_pkg::instr_u   instr;
  logic              commit;
  cpu_pkg::word_t    rdata;

  // Datapath to request unit
  cpu_pkg::word_t    pc;
  cpu_pkg::mem_req_t mem_req;

  datapath #(
    .PC_INIT (PC_INIT)
  ) i_datapath (
    .CLK     (CLK),
    .nRST    (nRST),
    .instr   (instr),
    .commit  (commit),
    .rdata   (rdata),
    .pc      (pc),
    .mem_req (mem_req),
    .halt    (halt)
  );

  request_unit i_request (
    .CLK     (CLK),
    .nRST    (nRST),
    .pc      (pc),
    .mem_req (mem_req),
    .halt    (halt),
    .wb_i    (wb_i),
    .instr   (instr),
    .commit  (commit),
    .rdata   (rdata),
    .wb_o    (wb_o)
  );

endmodule

// ==== design/datapath.sv ====
// #########################################################################
// Datapath for the single-issue core
// PC register and next-PC logic, immediate extender, operand and
// write-back muxes, halt flag, with control unit, register file and ALU
// #########################################################################

`timescale 1ns/1ps

module datapath #(
  parameter cpu_pkg::word_t PC_INIT = '0
) (
  input  logic               CLK,
  input  logic               nRST,
  input  cpu_pkg::instr_u    instr,
  input  logic               commit,
  input  cpu_pkg::word_t     rdata,
  output cpu_pkg::word_t     pc,
  output cpu_pkg::mem_req_t  mem_req,
  output logic               halt
);

  cpu_pkg::ctrl_t ctrl;

  // Register file ports
  logic [4:0]     wsel;
  cpu_pkg::word_t wdat;
  cpu_pkg::word_t rdat1;
  cpu_pkg::word_t rdat2;

  // Operands and results
  cpu_pkg::word_t ext_imm;
  cpu_pkg::word_t alu_b;
  cpu_pkg::word_t alu_result;
  logic           alu_zero;

  // Next-PC candidates
  cpu_pkg::word_t pc_plus4;
  cpu_pkg::word_t branch_target;
  cpu_pkg::word_t jump_target;
  cpu_pkg::word_t pc_next;
  logic           branch_taken;

  control_unit i_ctrl (
    .instr (instr),
    .ctrl  (ctrl)
  );

  register_file i_regs (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (ctrl.reg_write & commit),
    .wsel  (wsel),
    .wdat  (wdat),
    .rsel1 (instr.r.rs),
    .rsel2 (instr.r.rt),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  alu i_alu (
    .alu_op (ctrl.alu_op),
    .port_a (rdat1),
    .port_b (alu_b),
    .shamt  (instr.r.shamt),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // Sign or zero extension of imm16
  assign ext_imm = ctrl.ext_sign ? {{16{instr.i.imm16[15]}}, instr.i.imm16} :
                                   {16'b0, instr.i.imm16};
  assign alu_b   = ctrl.alu_src_imm ? ext_imm : rdat2;

  // $31 for JAL, else rd for R-type, rt for I-type
  assign wsel = ctrl.link       ? 5'd31       :
                ctrl.reg_dst_rd ? instr.r.rd  : instr.r.rt;

  always_comb begin
    case (ctrl.wb_sel)
      cpu_pkg::WB_MEM: wdat = rdata;
      cpu_pkg::WB_PC4: wdat = pc_plus4;
      default:         wdat = alu_result;
    endcase
  end

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + (ext_imm << 2);
  // Region of the current PC, word index from the instruction
  assign jump_target   = {pc[31:28], instr.j.addr26, 2'b00};
  assign branch_taken  = (ctrl.branch_eq & alu_zero) |
                         (ctrl.branch_ne & ~alu_zero);

  always_comb begin
    case (ctrl.jump)
      cpu_pkg::JMP_TARGET: pc_next = jump_target;
      cpu_pkg::JMP_REG:    pc_next = rdat1;
      default:             pc_next = branch_taken ? branch_target : pc_plus4;
    endcase
  end

  // PC moves only when the instruction retires
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (commit) begin
      pc <= pc_next;
    end
  end

  // Sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (commit && ctrl.halt) begin
      halt <= 1'b1;
    end
  end

  // Data access request, address from the ALU, store data from rt
  assign mem_req.read  = ctrl.mem_read;
  assign mem_req.write = ctrl.mem_write;
  assign mem_req.addr  = alu_result;
  assign mem_req.wdata = rdat2;

endmodule

// ==== design/register_file.sv ====
// #########################################################################
// Register file, 32 x 32 bits
// Register 0 reads as zero, two combinational reads, one clocked write
// #########################################################################

`timescale 1ns/1ps

module register_file (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           wen,
  input  logic [4:0]     wsel,
  input  cpu_pkg::word_t wdat,
  input  logic [4:0]     rsel1,
  input  logic [4:0]     rsel2,
  output cpu_pkg::word_t rdat1,
  output cpu_pkg::word_t rdat2
);

  // Only 31 real registers, $0 is implied
  cpu_pkg::word_t regs [31:1];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (wen && (wsel != 5'd0)) begin
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = (rsel1 == 5'd0) ? '0 : regs[rsel1];
  assign rdat2 = (rsel2 == 5'd0) ? '0 : regs[rsel2];

endmodule

// ==== design/request_unit.sv ====
// #########################################################################
// Request unit
// FETCH/EXEC/DATA sequencer, instruction register and the
// Wishbone classic master shared by fetch and data access
// #########################################################################

`timescale 1ns/1ps

module request_unit (
  input  logic              CLK,
  input  logic              nRST,
  input  cpu_pkg::word_t    pc,
  input  cpu_pkg::mem_req_t mem_req,
  input  logic              halt,
  input  cpu_pkg::wb_s_t    wb_i,
  output cpu_pkg::instr_u   instr,
  output logic              commit,
  output cpu_pkg::word_t    rdata,
  output cpu_pkg::wb_m_t    wb_o
);

  typedef enum logic [1:0] {FETCH, EXEC, DATA} state_t;

  state_t state;
  state_t state_nxt;
  logic   bus_ack;
  logic   mem_access;
  // Forces a dead bus cycle after every ack, high through reset
  logic   idle_q;

  assign mem_access = mem_req.read | mem_req.write;
  assign bus_ack    = wb_o.stb & wb_i.ack;

  always_comb begin
    state_nxt = state;
    case (state)
      FETCH: if (bus_ack) state_nxt = EXEC;
      EXEC:  state_nxt = mem_access ? DATA : FETCH;
      DATA:  if (bus_ack) state_nxt = FETCH;
      default: state_nxt = FETCH;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= FETCH;
      idle_q <= 1'b1;
    end else begin
      state  <= state_nxt;
      idle_q <= bus_ack;
    end
  end

  // Instruction register, loaded on fetch ack
  always_ff @(posedge CLK) begin
    if ((state == FETCH) && bus_ack) begin
      instr <= wb_i.dat;
    end
  end

  // Retire: no-access instructions in EXEC, others on data ack
  assign commit = ((state == EXEC) && !mem_access) || ((state == DATA) && bus_ack);
  assign rdata  = wb_i.dat;

  // No new fetch once halted
  always_comb begin
    wb_o.stb = (((state == FETCH) && !halt) || (state == DATA)) && !idle_q;
    wb_o.cyc = wb_o.stb;
    wb_o.we  = (state == DATA) && mem_req.write;
    wb_o.adr = (state == DATA) ? mem_req.addr : pc;
    wb_o.dat = (state == DATA) ? mem_req.wdata : '0;
    wb_o.sel = 4'hf;
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module cpu_tb -o cpu_sim

output=$(./obj_dir/cpu_sim)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi

// ==== verification/cpu_chk.sv ====
// ##########################################################################
// Wishbone protocol, reset and halt assertions for cpu_top
// Bound to every cpu_top instance
// ##########################################################################

`timescale 1ns/1ps

module cpu_chk (
  input logic           CLK,
  input logic           nRST,
  input cpu_pkg::wb_m_t wb_o,
  input cpu_pkg::wb_s_t wb_i,
  input logic           halt
);

  // Classic cycle, cyc and stb move together
  assert property (@(posedge CLK) disable iff (!nRST) wb_o.cyc == wb_o.stb)
    else $error("cyc and stb differ");

  // Request held until ack
  assert property (@(posedge CLK) disable iff (!nRST)
    (wb_o.stb && !wb_i.ack) |=> wb_o.stb && $stable(wb_o.adr) &&
                                $stable(wb_o.we) && $stable(wb_o.dat))
    else $error("bus request changed before ack");

  // Dead cycle after each ack
  assert property (@(posedge CLK) disable iff (!nRST)
    (wb_o.stb && wb_i.ack) |=> !wb_o.stb)
    else $error("stb still high the cycle after ack");

  assert property (@(posedge CLK) disable iff (!nRST)
    wb_o.stb |-> (wb_o.adr[1:0] == 2'b00) && (wb_o.sel == 4'hf))
    else $error("unaligned address or partial byte select");

  // Quiet bus during reset
  assert property (@(posedge CLK) !nRST |-> !wb_o.cyc && !wb_o.stb && !halt)
    else $error("bus or halt active during reset");

  // Halt is sticky
  assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else $error("halt dropped before reset");

  // Nothing new starts once halted
  assert property (@(posedge CLK) disable iff (!nRST)
    (halt && !wb_o.stb) |=> !wb_o.stb)
    else $error("new bus cycle started after halt");

endmodule

bind cpu_top cpu_chk i_chk (
  .CLK  (CLK),
  .nRST (nRST),
  .wb_o (wb_o),
  .wb_i (wb_i),
  .halt (halt)
);

// ==== verification/cpu_tb.sv ====
// ##########################################################################
// Testbench for the MIPS-subset core
// Clock and reset, Wishbone slave memory with a hand-assembled program,
// random wait states, store table checks, timeout and closing line
// ##########################################################################

`timescale 1ns/1ps

module cpu_tb;

  localparam cpu_pkg::word_t PC_INIT     = 32'h0000_0040;
  localparam cpu_pkg::word_t POISON      = 32'hDEAD_BEEF;
  // About 40 instructions of up to two 5-cycle bus cycles, 10x margin
  localparam int             CYCLE_LIMIT = 4000;
  localparam int             N_EXP       = 17;

  logic           CLK  = 1'b0;
  logic           nRST = 1'b1;
  cpu_pkg::wb_m_t wb_o;
  cpu_pkg::wb_s_t wb_i = '0;
  logic           halt;

  cpu_pkg::word_t mem [0:255];
  // Expected stores filled before reset
  cpu_pkg::word_t exp_addr [N_EXP];
  cpu_pkg::word_t exp_data [N_EXP];
  bit             stored   [N_EXP];
  int             exp_count    = 0;
  int             bus_errors   = 0;
  int             other_errors = 0;
  int             cycles       = 0;
  int             load_idx;
  bit             first_seen   = 1'b0;
  logic [31:0]    rng          = 32'h543909fb;
  logic [1:0]     wait_left    = 2'd0;

  cpu_top #(
    .PC_INIT (PC_INIT)
  ) i_dut (
    .CLK  (CLK),
    .nRST (nRST),
    .wb_o (wb_o),
    .wb_i (wb_i),
    .halt (halt)
  );

  initial begin
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
  end

  // Numerical Recipes LCG
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Small assemblers for the three formats
  function automatic cpu_pkg::word_t enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
    return {6'b000000, rs, rt, rd, sh, fn};
  endfunction

  function automatic cpu_pkg::word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic cpu_pkg::word_t enc_j(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic put(input cpu_pkg::word_t w);
    mem[load_idx] = w;
    load_idx++;
  endtask

  task automatic add_expect(input cpu_pkg::word_t adr, input cpu_pkg::word_t dat);
    exp_addr[exp_count] = adr;
    exp_data[exp_count] = dat;
    exp_count++;
  endtask

  task automatic load_program();
    // Background pattern tied to the word index
    for (int k = 0; k < 256; k++) begin
      mem[k] = {24'hC0FFEE, k[7:0]};
    end
    mem[128] = 32'h1234_5678;
    load_idx = 16;
    // 0x40 constants
    put(enc_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0005));
    put(enc_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd2, 16'hFFFD));
    put(enc_i(cpu_pkg::OP_LUI, 5'd0, 5'd3, 16'h1234));
    put(enc_i(cpu_pkg::OP_ORI, 5'd3, 5'd3, 16'hABCD));
    // 0x50 R-type ALU ops
    put(enc_r(cpu_pkg::FN_ADDU, 5'd1, 5'd2, 5'd4, 5'd0));
    put(enc_r(cpu_pkg::FN_SUBU, 5'd1, 5'd2, 5'd5, 5'd0));
    put(enc_r(cpu_pkg::FN_AND, 5'd3, 5'd1, 5'd6, 5'd0));
    put(enc_r(cpu_pkg::FN_OR, 5'd1, 5'd2, 5'd7, 5'd0));
    put(enc_r(cpu_pkg::FN_XOR, 5'd3, 5'd2, 5'd8, 5'd0));
    put(enc_r(cpu_pkg::FN_NOR, 5'd1, 5'd0, 5'd9, 5'd0));
    put(enc_r(cpu_pkg::FN_SLT, 5'd2, 5'd1, 5'd10, 5'd0));
    put(enc_r(cpu_pkg::FN_SLTU, 5'd2, 5'd1, 5'd11, 5'd0));
    put(enc_i(cpu_pkg::OP_SLTI, 5'd2, 5'd12, 16'hFFFE));
    put(enc_r(cpu_pkg::FN_SLL, 5'd0, 5'd1, 5'd13, 5'd4));
    put(enc_r(cpu_pkg::FN_SRL, 5'd0, 5'd3, 5'd14, 5'd8));
    // Attempted write to $0
    put(enc_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h0077));
    // 0x80 stores of $4 to $14 then $0 and $3
    for (int r = 4; r <= 14; r++) begin
      put(enc_i(cpu_pkg::OP_SW, 5'd0, r[4:0], 16'h0300 + 16'((r - 4) * 4)));
    end
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd0, 16'h032C));
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd3, 16'h0330));
    // 0xB4 load then add and store
    put(enc_i(cpu_pkg::OP_LW, 5'd0, 5'd15, 16'h0200));
    put(enc_i(cpu_pkg::OP_ADDIU, 5'd15, 5'd15, 16'h0011));
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd15, 16'h0334));
    // 0xC0 poison into $20
    put(enc_i(cpu_pkg::OP_LUI, 5'd0, 5'd20, 16'hDEAD));
    put(enc_i(cpu_pkg::OP_ORI, 5'd20, 5'd20, 16'hBEEF));
    // 0xC8 two branches not taken then two taken
    // A wrongly taken branch lands on a poison store
    put(enc_i(cpu_pkg::OP_BEQ, 5'd1, 5'd2, 16'h0002));
    put(enc_i(cpu_pkg::OP_BNE, 5'd1, 5'd1, 16'h0001));
    put(enc_i(cpu_pkg::OP_BEQ, 5'd1, 5'd1, 16'h0001));
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd20, 16'h0338));
    put(enc_i(cpu_pkg::OP_BNE, 5'd1, 5'd2, 16'h0001));
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd20, 16'h0338));
    // 0xE0 J to 0xE8 then JAL to 0x100
    put(enc_j(cpu_pkg::OP_J, 26'h000003A));
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd20, 16'h0338));
    put(enc_j(cpu_pkg::OP_JAL, 26'h0000040));
    // 0xEC return point
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd31, 16'h033C));
    put(enc_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd16, 16'h0001));
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd16, 16'h0340));
    put(32'hFFFF_FFFF);
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd20, 16'h0338));
    // 0x100 subroutine
    put(enc_i(cpu_pkg::OP_ADDIU, 5'd0, 5'd17, 16'h0042));
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd17, 16'h0344));
    put(enc_r(cpu_pkg::FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
    put(enc_i(cpu_pkg::OP_SW, 5'd0, 5'd20, 16'h0338));
  endtask

  task automatic check_store(input cpu_pkg::word_t adr, input cpu_pkg::word_t dat);
    int idx;
    idx = -1;
    for (int k = 0; k < exp_count; k++) begin
      if (exp_addr[k] == adr) idx = k;
    end
    assert (dat != POISON) else begin
      bus_errors++;
      $display("Poison value stored at %08h, a skipped slot was executed", adr);
    end
    assert (dat == POISON || idx >= 0) else begin
      bus_errors++;
      $display("Store to unexpected address %08h", adr);
    end
    if (dat != POISON && idx >= 0) begin
      assert (dat == exp_data[idx]) else begin
        bus_errors++;
        $display("Mismatch wb_o.dat at %08h: got %08h, expected %08h", adr, dat,
                 exp_data[idx]);
      end
      stored[idx] = 1'b1;
    end
  endtask

  // Slave memory driving ack and data on the falling edge
  initial begin
    load_program();
    forever begin
      @(negedge CLK);
      if (!nRST) begin
        wb_i <= '0;
      end else if (wb_i.ack) begin
        // Drop ack and draw the wait for the next cycle
        wb_i.ack  <= 1'b0;
        rng        = lcg_next(rng);
        wait_left <= rng[17:16];
      end else if (wb_o.stb) begin
        if (!first_seen) begin
          first_seen = 1'b1;
          assert (wb_o.adr == PC_INIT && !wb_o.we) else begin
            bus_errors++;
            $display("First bus cycle was not a read at PC_INIT (adr %08h)", wb_o.adr);
          end
        end
        if (wait_left != 2'd0) begin
          wait_left <= wait_left - 2'd1;
        end else begin
          wb_i.ack <= 1'b1;
          if (wb_o.we) begin
            mem[wb_o.adr[9:2]] = wb_o.dat;
            check_store(wb_o.adr, wb_o.dat);
          end else begin
            wb_i.dat <= mem[wb_o.adr[9:2]];
          end
        end
      end
    end
  end

  initial begin
    // Expected results of the program's stores
    add_expect(32'h300, 32'h0000_0002);
    add_expect(32'h304, 32'h0000_0008);
    add_expect(32'h308, 32'h0000_0005);
    add_expect(32'h30C, 32'hFFFF_FFFD);
    add_expect(32'h310, 32'hEDCB_5430);
    add_expect(32'h314, 32'hFFFF_FFFA);
    add_expect(32'h318, 32'h0000_0001);
    add_expect(32'h31C, 32'h0000_0000);
    add_expect(32'h320, 32'h0000_0001);
    add_expect(32'h324, 32'h0000_0050);
    add_expect(32'h328, 32'h0012_34AB);
    add_expect(32'h32C, 32'h0000_0000);
    add_expect(32'h330, 32'h1234_ABCD);
    add_expect(32'h334, 32'h1234_5689);
    add_expect(32'h33C, 32'h0000_00EC);
    add_expect(32'h340, 32'h0000_0001);
    add_expect(32'h344, 32'h0000_0042);
    // Reset edge ahead of the first rising clock edge
    #1 nRST = 1'b0;
    repeat (16) @(negedge CLK);
    nRST = 1'b1;
    while (!halt && cycles < CYCLE_LIMIT) @(negedge CLK);
    if (!halt) begin
      other_errors++;
      $display("timeout before halt");
    end
    // A few idle cycles for the halt assertions
    repeat (8) @(negedge CLK);
    for (int k = 0; k < exp_count; k++) begin
      assert (stored[k]) else begin
        other_errors++;
        $display("No store seen to address %08h", exp_addr[k]);
      end
    end
    assert (first_seen) else begin
      other_errors++;
      $display("No bus cycle seen after reset");
    end
    $display("Done: %0d bus errors, %0d other errors", bus_errors, other_errors);
    if (bus_errors == 0 && other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
